/* board_pkg.sv */
// Shared types and timing constants for the microphone display board design
package board_pkg;

    // ----------------------------------------
    // Data types

    typedef logic signed [23:0] sample_t;  // One microphone sample
    typedef logic        [7:0]  seg_t;     // abcdefgh, a is the top bit
    typedef logic        [9:0]  led_t;     // Level bar

    // I2S half-frame currently selected by ws
    typedef enum logic
    {
        mic_left  = 1'b0,   // ws low
        mic_right = 1'b1    // ws high
    } mic_channel_t;

    // ----------------------------------------
    // Display

    localparam int w_digit      = 6;
    localparam int digit_cycles = 256;  // clk per digit in the scan

    localparam int w_refresh    = $clog2(digit_cycles);
    localparam int w_digit_idx  = $clog2(w_digit);

    // ----------------------------------------
    // I2S timing

    localparam int sck_half_cycles  = 8;   // clk per sck half period
    localparam int bits_per_channel = 32;  // sck periods per half-frame
    localparam int sample_bits      = 24;

    localparam int w_sck_cnt = $clog2(sck_half_cycles);
    localparam int w_bit_cnt = $clog2(bits_per_channel);

    // ----------------------------------------
    // Level bar

    // Bar length is the top set bit of the magnitude minus this
    localparam int level_shift = 13;

endpackage

/* inmp441_mic_i2s_receiver.sv */
// I2S master for the INMP441 microphone, producing sck and ws and capturing left samples
module inmp441_mic_i2s_receiver
(
    input  logic               clk,
    input  logic               rst,
    output logic               lr,
    output logic               ws,
    output logic               sck,
    input  logic               sd,
    output board_pkg::sample_t value,
    output logic               value_valid
);

    // ----------------------------------------
    // Bit clock divider

    logic [board_pkg::w_sck_cnt - 1:0] div_cnt;
    logic                              sck_toggle;
    logic                              sck_rise;
    logic                              sck_fall;

    assign sck_toggle = (div_cnt == board_pkg::w_sck_cnt'(board_pkg::sck_half_cycles - 1));
    assign sck_rise   = sck_toggle & ~sck;
    assign sck_fall   = sck_toggle &  sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_toggle)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Half-frame bit counter and channel phase

    logic [board_pkg::w_bit_cnt - 1:0] bit_cnt;
    board_pkg::mic_channel_t           channel;
    logic                              last_bit;
    logic                              frame_ok;   // Left half began on a real ws edge

    assign last_bit = (bit_cnt == board_pkg::w_bit_cnt'(board_pkg::bits_per_channel - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt  <= '0;
            channel  <= board_pkg::mic_left;
            frame_ok <= 1'b0;
        end
        else if (sck_fall)
        begin
            if (last_bit)
            begin
                bit_cnt <= '0;
                if (channel == board_pkg::mic_left)
                begin
                    channel <= board_pkg::mic_right;
                end
                else
                begin
                    channel  <= board_pkg::mic_left;
                    frame_ok <= 1'b1;
                end
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign ws = (channel == board_pkg::mic_right);
    assign lr = 1'b0;  // Mic answers in the left slot

    // ----------------------------------------
    // Data capture

    board_pkg::sample_t shift;
    logic               in_window;
    logic               ws_q;
    logic               ws_rise;

    // MSB arrives in the second sck period of the half
    assign in_window = (channel == board_pkg::mic_left)
                     && (bit_cnt != '0)
                     && (bit_cnt <= board_pkg::w_bit_cnt'(board_pkg::sample_bits));

    assign ws_rise = ws & ~ws_q;

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_window)
            shift <= {shift[$bits(shift) - 2:0], sd};
        if (ws_rise)
            value <= shift;   // Full word is in by the end of the left half
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ws_q        <= 1'b0;
            value_valid <= 1'b0;
        end
        else
        begin
            ws_q        <= ws;
            value_valid <= ws_rise & frame_ok;
        end
    end

endmodule

/* seven_segment_display.sv */
// Scanned six digit hex display driver with one-hot digit select
module seven_segment_display
(
    input  logic                             clk,
    input  logic                             rst,
    input  board_pkg::sample_t               number,
    output board_pkg::seg_t                  abcdefgh,
    output logic [board_pkg::w_digit - 1:0]  digit
);

    // ----------------------------------------
    // Digit scan

    logic [board_pkg::w_refresh   - 1:0] refresh;
    logic [board_pkg::w_digit_idx - 1:0] index;
    logic                                refresh_end;
    logic                                last_digit;

    assign refresh_end = (refresh == board_pkg::w_refresh'(board_pkg::digit_cycles - 1));
    assign last_digit  = (index == board_pkg::w_digit_idx'(board_pkg::w_digit - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            refresh <= '0;
            index   <= '0;
        end
        else if (refresh_end)
        begin
            refresh <= '0;
            index   <= last_digit ? '0 : index + 1'b1;
        end
        else
        begin
            refresh <= refresh + 1'b1;
        end
    end

    assign digit = board_pkg::w_digit'(1) << index;

    // ----------------------------------------
    // Hex glyph decoder

    logic [3:0] nibble;

    assign nibble = number[index * 4 +: 4];  // Digit 0 is the low nibble

    always_comb
    begin
        case (nibble)
            4'h0:    abcdefgh = 8'b1111_1100;
            4'h1:    abcdefgh = 8'b0110_0000;
            4'h2:    abcdefgh = 8'b1101_1010;
            4'h3:    abcdefgh = 8'b1111_0010;
            4'h4:    abcdefgh = 8'b0110_0110;
            4'h5:    abcdefgh = 8'b1011_0110;
            4'h6:    abcdefgh = 8'b1011_1110;
            4'h7:    abcdefgh = 8'b1110_0000;
            4'h8:    abcdefgh = 8'b1111_1110;
            4'h9:    abcdefgh = 8'b1111_0110;
            4'ha:    abcdefgh = 8'b1110_1110;
            4'hb:    abcdefgh = 8'b0011_1110;  // Lower case b
            4'hc:    abcdefgh = 8'b1001_1100;
            4'hd:    abcdefgh = 8'b0111_1010;  // Lower case d
            4'he:    abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;  // F
        endcase
    end

endmodule

/* top.sv */
// Microphone lab design with sample hold, freeze key, level bar and hex display
module top
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [1:0]                      key,
    output board_pkg::led_t                 led,
    output board_pkg::seg_t                 abcdefgh,
    output logic [board_pkg::w_digit - 1:0] digit,
    input  board_pkg::sample_t              mic,
    input  logic                            mic_valid
);

    // ----------------------------------------
    // Sample hold

    board_pkg::sample_t held;
    logic               shown;    // Set once a sample has been taken
    logic               freeze;

    assign freeze = key[0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            held  <= '0;
            shown <= 1'b0;
        end
        else if (mic_valid && !freeze)
        begin
            held  <= mic;
            shown <= 1'b1;
        end
    end

    // ----------------------------------------
    // Level bar

    logic [board_pkg::sample_bits - 1:0] mag;
    board_pkg::led_t                     level;

    always_comb
    begin
        // Negating the most negative value gives 2^23 in unsigned form
        mag = held[$left(held)] ? unsigned'(-held) : unsigned'(held);
        for (int k = 0; k < $bits(board_pkg::led_t); k++)
            level[k] = (mag >> (board_pkg::level_shift + 1 + k)) != '0;  // Thermometer
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else
            led <= level;
    end

    // ----------------------------------------
    // Display

    board_pkg::seg_t disp_seg;

    seven_segment_display i_display
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .number   ( held     ),
        .abcdefgh ( disp_seg ),
        .digit    ( digit    )
    );

    assign abcdefgh = shown ? disp_seg : '0;  // Dark until the first sample

endmodule

/* board_specific_top.sv */
// DE10-Lite style board wrapper around the microphone lab with sticky HEX registers
module board_specific_top
(
    input  logic            MAX10_CLK1_50,
    input  logic [1:0]      KEY,
    input  logic [9:0]      SW,
    output logic [9:0]      LEDR,
    output board_pkg::seg_t HEX0,
    output board_pkg::seg_t HEX1,
    output board_pkg::seg_t HEX2,
    output board_pkg::seg_t HEX3,
    output board_pkg::seg_t HEX4,
    output board_pkg::seg_t HEX5,
    inout  wire  [35:0]     GPIO
);

    // ----------------------------------------
    // Clock, reset and keys

    logic       clk;
    logic       rst;
    logic [1:0] key;

    assign clk = MAX10_CLK1_50;
    assign rst = SW[9];
    assign key = ~KEY;   // Keys are active low on the board

    // ----------------------------------------
    // Lab design

    board_pkg::seg_t                 abcdefgh;
    logic [board_pkg::w_digit - 1:0] digit;
    board_pkg::sample_t              mic;
    logic                            mic_valid;

    top i_top
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .led       ( LEDR      ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     ),
        .mic       ( mic       ),
        .mic_valid ( mic_valid )
    );

    // ----------------------------------------
    // Sticky HEX registers

    board_pkg::seg_t hgfedcba;
    board_pkg::seg_t hex_q [board_pkg::w_digit];

    assign hgfedcba = {<<{abcdefgh}};  // HEX bit 0 is segment a

    // Each display keeps the last pattern scanned into it
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < board_pkg::w_digit; i++)
                hex_q[i] <= '1;   // Segments are active low
        end
        else
        begin
            for (int i = 0; i < board_pkg::w_digit; i++)
                if (digit[i])
                    hex_q[i] <= ~hgfedcba;
        end
    end

    assign HEX0 = hex_q[0];
    assign HEX1 = hex_q[1];
    assign HEX2 = hex_q[2];
    assign HEX3 = hex_q[3];
    assign HEX4 = hex_q[4];
    assign HEX5 = hex_q[5];

    // ----------------------------------------
    // Microphone on the GPIO header

    logic mic_lr;
    logic mic_ws;
    logic mic_sck;
    logic mic_sd;

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .lr          ( mic_lr    ),
        .ws          ( mic_ws    ),
        .sck         ( mic_sck   ),
        .sd          ( mic_sd    ),
        .value       ( mic       ),
        .value_valid ( mic_valid )
    );

    assign GPIO[0] = mic_lr;    // Channel select
    assign GPIO[1] = 1'b0;      // Mic ground
    assign GPIO[2] = mic_ws;
    assign GPIO[3] = 1'b1;      // Mic supply
    assign GPIO[4] = mic_sck;
    assign mic_sd  = GPIO[5];   // Serial data from the mic

endmodule

/* board_chk.sv */
// Assertions on the display scan and I2S signals of top and the mic receiver
module board_chk
(
    input logic                            clk,
    input logic                            rst,
    input logic [board_pkg::w_digit - 1:0] digit,
    input logic                            value_valid,
    input logic                            ws,
    input logic                            sck
);

    // ----------------------------------------
    // Display scan

    digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(digit))
        else $error("digit select is not one-hot: %b", digit);

    // ----------------------------------------
    // Receiver

    valid_pulse: assert property (@(posedge clk) disable iff (rst) value_valid |=> !value_valid)
        else $error("value_valid lasted more than one cycle");

    // ws moves on the sck falling edge only
    ws_on_sck_low: assert property (@(posedge clk) disable iff (rst) $changed(ws) |-> !sck)
        else $error("ws changed while sck was high");

endmodule

bind board_specific_top board_chk i_board_chk
(
    .clk         ( clk       ),
    .rst         ( rst       ),
    .digit       ( digit     ),
    .value_valid ( mic_valid ),
    .ws          ( mic_ws    ),
    .sck         ( mic_sck   )
);

/* tb_board_specific_top.sv */
// Testbench for the microphone board wrapper with an I2S mic model and display checks
module tb_board_specific_top;

    localparam int clk_period = 8;
    localparam int frame_clk  = 4 * board_pkg::bits_per_channel * board_pkg::sck_half_cycles;
    localparam int settle_clk = 1600;   // One full scan plus margin
    localparam int n_tests    = 6;
    localparam int n_samples  = 30;
    localparam longint watchdog_time = 2 * n_tests * n_samples * 3 * frame_clk * clk_period;

    // Segment codes in gfedcba order for hex 0 to F
    localparam logic [6:0] glyphs [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
        7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    logic            clk;
    logic [1:0]      key;
    logic [9:0]      sw;
    logic [9:0]      ledr;
    board_pkg::seg_t hex [6];
    wire  [35:0]     gpio;
    logic            sd = 1'b0;

    int errors        = 0;
    int checks        = 0;
    int tests_run     = 0;
    int tests_failed  = 0;
    int errors_before = 0;

    board_specific_top i_board_specific_top
    (
        .MAX10_CLK1_50 ( clk    ),
        .KEY           ( key    ),
        .SW            ( sw     ),
        .LEDR          ( ledr   ),
        .HEX0          ( hex[0] ),
        .HEX1          ( hex[1] ),
        .HEX2          ( hex[2] ),
        .HEX3          ( hex[3] ),
        .HEX4          ( hex[4] ),
        .HEX5          ( hex[5] ),
        .GPIO          ( gpio   )
    );

    assign gpio[5] = sd;   // Mic serial data

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ----------------------------------------
    // I2S microphone model

    board_pkg::sample_t tx_q [$];
    board_pkg::sample_t word     = '0;
    logic               sck_prev = 1'b0;
    logic               ws_prev  = 1'b0;
    int                 bit_pos  = 0;
    int                 frames   = 0;   // ws rising edges seen

    always @(posedge clk)
    begin
        sck_prev <= gpio[4];
        if (sw[9])
        begin
            ws_prev <= 1'b0;
            bit_pos <= 0;
            sd      <= 1'b0;
        end
        else if (sck_prev && !gpio[4])   // sck fell on the last edge
        begin
            ws_prev <= gpio[2];
            if (gpio[2] != ws_prev)
            begin
                bit_pos <= 0;
                sd      <= 1'b0;
                if (!gpio[2] && tx_q.size() != 0)
                    word <= tx_q.pop_front();   // New left word
                if (gpio[2])
                    frames <= frames + 1;
            end
            else
            begin
                bit_pos <= bit_pos + 1;
                // MSB goes out in the second sck period of the left half
                if (!gpio[2] && bit_pos < board_pkg::sample_bits)
                    sd <= word[board_pkg::sample_bits - 1 - bit_pos];
                else
                    sd <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Reference model and compare tasks

    function automatic board_pkg::seg_t expected_hex(board_pkg::sample_t sample, int i);
        logic [3:0] nib;
        nib = sample[i * 4 +: 4];
        return ~{1'b0, glyphs[nib]};   // Dot off, segments active low
    endfunction

    function automatic board_pkg::led_t expected_led(board_pkg::sample_t sample);
        int mag;
        int n;
        mag = int'(sample);
        if (mag < 0)
            mag = -mag;
        n = 0;
        for (int b = 0; b < board_pkg::sample_bits; b++)
            if (mag[b])
                n = b - 13;   // Highest set bit wins
        if (n < 0)
            n = 0;
        if (n > 10)
            n = 10;
        return board_pkg::led_t'((1 << n) - 1);
    endfunction

    task automatic check_hex(int idx, board_pkg::seg_t got, board_pkg::seg_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: HEX%0d got %b expected %b", $time, idx, got, exp);
        end
    endtask

    task automatic check_led(board_pkg::led_t got, board_pkg::led_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: LEDR got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_pin(string name, logic got, logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Compare process, started by run_check
    board_pkg::sample_t exp_sample = '0;
    logic               exp_blank  = 1'b1;
    int                 exp_wait   = 0;
    logic               check_busy = 1'b0;

    initial
    begin
        forever
        begin
            wait (check_busy);
            repeat (exp_wait) @(posedge clk);
            @(negedge clk);   // Outputs are stable here
            for (int i = 0; i < board_pkg::w_digit; i++)
                check_hex(i, hex[i], exp_blank ? 8'hff : expected_hex(exp_sample, i));
            check_led(ledr, exp_blank ? 10'h000 : expected_led(exp_sample));
            check_pin("GPIO[0]", gpio[0], 1'b0);   // lr picks the left slot
            check_pin("GPIO[1]", gpio[1], 1'b0);   // Mic ground
            check_pin("GPIO[3]", gpio[3], 1'b1);   // Mic supply
            if (sw[9])
            begin
                check_pin("GPIO[2]", gpio[2], 1'b0);   // ws idles low in reset
                check_pin("GPIO[4]", gpio[4], 1'b0);   // sck idles low in reset
            end
            check_busy = 1'b0;
        end
    end

    // ----------------------------------------
    // Stimulus

    board_pkg::sample_t last_sample = '0;

    task automatic run_check(board_pkg::sample_t sample, logic blank, int wait_clk);
        exp_sample = sample;
        exp_blank  = blank;
        exp_wait   = wait_clk;
        check_busy = 1'b1;
        wait (!check_busy);
    endtask

    task automatic send_sample(board_pkg::sample_t sample);
        int target;
        int waited;
        repeat (3) tx_q.push_back(sample);
        target = frames + 3;
        waited = 0;
        while (frames < target && waited < 4 * frame_clk)
        begin
            @(posedge clk);
            waited++;
        end
        if (frames < target)
        begin
            errors++;
            $display("No ws edges from the DUT within %0d clk while sending %h", waited, sample);
        end
    endtask

    task automatic show_sample(board_pkg::sample_t sample);
        send_sample(sample);
        run_check(sample, 1'b0, settle_clk);
        last_sample = sample;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == errors_before)
            $display("Test %0d %s passed", tests_run, name);
        else
        begin
            tests_failed++;
            $display("Test %0d %s failed with %0d errors", tests_run, name,
                errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial
    begin
        board_pkg::sample_t rnd;
        void'($urandom(32'h7d14));
        key = 2'b11;
        sw  = 10'h200;   // Reset held on SW[9]
        repeat (5) @(posedge clk);
        sw[9] <= 1'b0;

        run_check('0, 1'b1, 16);
        end_test("reset_state");

        show_sample(24'h000001);
        show_sample(24'h123456);
        show_sample(24'h7fffff);
        end_test("positive");

        show_sample(24'hffffff);
        show_sample(24'h800000);
        show_sample(24'habcdef);
        end_test("negative");

        @(posedge clk);
        key[0] <= 1'b0;   // Freeze pressed
        send_sample(24'h0f0f0f);
        run_check(last_sample, 1'b0, settle_clk);
        @(posedge clk);
        key[0] <= 1'b1;
        show_sample(24'h2468ac);
        end_test("freeze");

        for (int n = 0; n < 20; n++)
        begin
            rnd = board_pkg::sample_t'($urandom);
            show_sample(rnd);
        end
        end_test("random");

        @(posedge clk);
        sw[9] <= 1'b1;
        repeat (5) @(posedge clk);
        run_check('0, 1'b1, 0);
        @(posedge clk);
        sw[9] <= 1'b0;
        show_sample(24'h5a5a5a);
        end_test("mid_reset");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(watchdog_time);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog.f */
board_pkg.sv
inmp441_mic_i2s_receiver.sv
seven_segment_display.sv
top.sv
board_specific_top.sv
board_chk.sv
tb_board_specific_top.sv

/* Makefile */
TOP = tb_board_specific_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
